// File: verif/ex_stage_testdata.txt
// unit op a b imm pc flags pred_target tag exp_result exp_target exp_branch (all hex)
// unit 0 alu 1 branch 2 csr 3 mult, flags bit0 compressed bit1 predicted taken, exp_branch bit2 resolve bit1 mispredict bit0 taken
0 00 00000005 00000003 00000000 00001000 0 00000000 1 00000008 00000000 0
0 01 00000003 00000005 00000000 00001004 0 00000000 2 fffffffe 00000000 0
0 02 f0f0f0f0 ff00ff00 00000000 00001008 0 00000000 3 f000f000 00000000 0
0 03 f0f0f0f0 0f0f0000 00000000 0000100c 0 00000000 4 fffff0f0 00000000 0
0 04 aaaaaaaa ffff0000 00000000 00001010 0 00000000 5 5555aaaa 00000000 0
0 05 00000001 00000024 00000000 00001014 0 00000000 6 00000010 00000000 0
0 06 80000000 0000001f 00000000 00001018 0 00000000 7 00000001 00000000 0
0 07 80000000 00000004 00000000 0000101c 0 00000000 0 f8000000 00000000 0
0 08 ffffffff 00000001 00000000 00001020 0 00000000 1 00000001 00000000 0
0 09 ffffffff 00000001 00000000 00001024 0 00000000 2 00000000 00000000 0
0 00 00000010 00000020 00000000 00002000 2 00002400 3 00000030 00002004 6
0 04 0000ffff 000000ff 00000000 00002100 3 00000000 4 0000ff00 00002102 6
1 0a 00000005 00000005 00000040 00003000 2 00003040 5 00003004 00003040 5
1 0b 00000005 00000005 00000040 00003100 2 00003140 6 00003104 00003104 6
1 0c fffffff0 00000001 fffffff0 00003200 1 00000000 7 00003202 000031f0 7
1 0f 00000001 fffffff0 00000020 00003300 0 00000000 0 00003304 00003304 4
1 10 00000000 00000000 00000100 00004000 3 00004100 1 00004002 00004100 5
1 11 00005003 00000000 00000010 00004100 2 00005010 2 00004104 00005012 7
3 13 00010003 00020005 00000000 00000000 0 00000000 6 000b000f 00000000 0
3 14 ffffffff ffffffff 00000000 00000000 0 00000000 7 fffffffe 00000000 0
2 12 deadbeef 00000000 00000305 00000000 0 00000000 0 deadbeef 00000305 0
2 15 80001000 000001a5 00000000 00000000 0 00000000 1 80001000 00000000 0
2 12 12345678 00000000 fffff341 00000000 0 00000000 2 12345678 00000341 0

// File: filelist.f
src/ex_pkg.sv
src/ex_issue_gate.sv
src/alu.sv
src/branch_unit.sv
src/csr_buffer.sv
src/multiplier.sv
src/flu_writeback.sv
src/ex_stage.sv
verif/ex_stage_sva.sv
verif/ex_stage_tb.sv

// File: Makefile
# Verilator flow for the execute stage testbench
TOP := ex_stage_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: verif/ex_stage_tb.sv
/*
 * Testbench for the execute stage: clock and reset, operations read
 * from the data file, random idle gaps and typed compare tasks
 */
`timescale 1ns/100ps

module ex_stage_tb import ex_pkg::*; ();

    // Words per record in the data file
    localparam int FIELDS  = 12;
    localparam int NUM_OPS = 23;

    logic      clk_i, rst_ni, flush_i, csr_commit_i;
    fu_op_t    operator_i;
    xlen_t     operand_a_i, operand_b_i, imm_i, rs2_fwd_i;
    trans_id_t trans_id_i;
    logic      alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i;
    vaddr_t    pc_i, predict_target_i, rs1_fwd_i;
    logic      is_compressed_i, predict_taken_i;
    logic      flu_valid_o, flu_ready_o, resolve_branch_o;
    xlen_t     flu_result_o;
    trans_id_t flu_trans_id_o;
    vaddr_t    resolved_pc_o, resolved_target_o, sfence_vaddr_o;
    logic      resolved_taken_o, resolved_mispredict_o, sfence_pending_o;
    csr_addr_t csr_addr_o;
    asid_t     sfence_asid_o;

    logic [31:0] vec_mem [0:FIELDS*NUM_OPS-1];
    int          seed = 32'h0204adfd;

    ex_stage UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Timing and compare helpers
    // ----------------------------------------
    // Inputs change 2 ns after the edge, outputs read at mid cycle
    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    task automatic settle();
        #8;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        $display("RESULT: FAIL");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_result(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_tag(input string what, input trans_id_t got, input trans_id_t exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_target(input string what, input vaddr_t got, input vaddr_t exp);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_addr(input string what, input csr_addr_t got, input csr_addr_t exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_asid(input string what, input asid_t got, input asid_t exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic clear_strobes();
        alu_valid_i    = 1'b0;
        branch_valid_i = 1'b0;
        csr_valid_i    = 1'b0;
        mult_valid_i   = 1'b0;
        flush_i        = 1'b0;
        csr_commit_i   = 1'b0;
    endtask

    // CSR issue needs a free buffer entry
    task automatic wait_ready();
        int cnt;
        cnt = 0;
        while (!flu_ready_o && cnt < 50) begin
            step();
            cnt++;
        end
        if (!flu_ready_o) begin
            $display("Timeout: flu_ready_o stayed low for 50 cycles");
            $display("RESULT: FAIL");
            $fatal(1, "ready timeout");
        end
    endtask

    // ----------------------------------------
    // One operation from the data file
    // ----------------------------------------
    task automatic run_op(input int idx);
        int          base;
        int          gap;
        logic [31:0] unit, flags, exp_br;
        fu_op_t      op;
        xlen_t       a, b, imm, exp_res;
        vaddr_t      pc, ptgt, exp_tgt;
        trans_id_t   tag;
        base    = idx * FIELDS;
        unit    = vec_mem[base];
        op      = fu_op_t'(vec_mem[base+1][4:0]);
        a       = vec_mem[base+2];
        b       = vec_mem[base+3];
        imm     = vec_mem[base+4];
        pc      = vec_mem[base+5];
        flags   = vec_mem[base+6];
        ptgt    = vec_mem[base+7];
        tag     = vec_mem[base+8][TRANS_ID_BITS-1:0];
        exp_res = vec_mem[base+9];
        exp_tgt = vec_mem[base+10];
        exp_br  = vec_mem[base+11];
        gap = 1 + ($random(seed) & 3);
        // Forwarded sources settle at least one cycle before issue
        step();
        rs1_fwd_i = a;
        rs2_fwd_i = b;
        repeat (gap) step();
        if (unit == 2) wait_ready();
        operator_i       = op;
        operand_a_i      = a;
        operand_b_i      = b;
        imm_i            = imm;
        pc_i             = pc;
        is_compressed_i  = flags[0];
        predict_taken_i  = flags[1];
        predict_target_i = ptgt;
        trans_id_i       = tag;
        case (unit)
            0: alu_valid_i    = 1'b1;
            1: branch_valid_i = 1'b1;
            2: csr_valid_i    = 1'b1;
            3: mult_valid_i   = 1'b1;
            default: begin
                $display("Data file record %0d names an unknown unit", idx);
                $display("RESULT: FAIL");
                $fatal(1, "bad data file");
            end
        endcase
        settle();
        // Resolution comes in the issue cycle
        check_bit("resolve_branch_o", resolve_branch_o, exp_br[2]);
        if (exp_br[2]) begin
            check_bit("resolved_taken_o", resolved_taken_o, exp_br[0]);
            check_bit("resolved_mispredict_o", resolved_mispredict_o, exp_br[1]);
            check_target("resolved_target_o", resolved_target_o, exp_tgt);
            check_target("resolved_pc_o", resolved_pc_o, pc);
        end
        // Zero-latency units write back at once
        if (unit != 3) begin
            check_bit("flu_valid_o", flu_valid_o, 1'b1);
            check_result("flu_result_o", flu_result_o, exp_res);
            check_tag("flu_trans_id_o", flu_trans_id_o, tag);
        end
        step();
        clear_strobes();
        predict_taken_i = 1'b0;
        // Issue tag moves on while the product is in flight
        trans_id_i      = ~tag;
        settle();
        if (unit == 3) begin
            check_bit("flu_valid_o", flu_valid_o, 1'b1);
            check_result("flu_result_o", flu_result_o, exp_res);
            check_tag("flu_trans_id_o", flu_trans_id_o, tag);
        end
        if (unit == 2) begin
            check_bit("flu_ready_o", flu_ready_o, 1'b0);
            check_addr("csr_addr_o", csr_addr_o, exp_tgt[CSR_ADDR_W-1:0]);
            if (op == SFENCE_VMA) begin
                check_bit("sfence_pending_o", sfence_pending_o, 1'b1);
                check_target("sfence_vaddr_o", sfence_vaddr_o, a);
                check_asid("sfence_asid_o", sfence_asid_o, b[ASID_W-1:0]);
                // New forwarded values must not reach the frozen copy
                step();
                rs1_fwd_i = ~a;
                rs2_fwd_i = ~b;
                flush_i   = 1'b1;
                settle();
                check_bit("sfence_pending_o", sfence_pending_o, 1'b1);
                step();
                flush_i = 1'b0;
                settle();
                check_bit("sfence_pending_o", sfence_pending_o, 1'b0);
                check_bit("flu_ready_o", flu_ready_o, 1'b1);
                check_target("sfence_vaddr_o", sfence_vaddr_o, a);
                check_asid("sfence_asid_o", sfence_asid_o, b[ASID_W-1:0]);
            end else begin
                step();
                csr_commit_i = 1'b1;
                settle();
                check_bit("flu_ready_o", flu_ready_o, 1'b0);
                check_addr("csr_addr_o", csr_addr_o, exp_tgt[CSR_ADDR_W-1:0]);
                step();
                csr_commit_i = 1'b0;
                settle();
                check_bit("flu_ready_o", flu_ready_o, 1'b1);
            end
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        $readmemh("verif/ex_stage_testdata.txt", vec_mem);
        rst_ni           = 1'b0;
        operator_i       = ADD;
        operand_a_i      = '0;
        operand_b_i      = '0;
        imm_i            = '0;
        trans_id_i       = '0;
        pc_i             = '0;
        is_compressed_i  = 1'b0;
        predict_taken_i  = 1'b0;
        predict_target_i = '0;
        rs1_fwd_i        = '0;
        rs2_fwd_i        = '0;
        clear_strobes();
        repeat (4) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        step();
        // Idle state out of reset
        check_bit("flu_valid_o", flu_valid_o, 1'b0);
        check_bit("resolve_branch_o", resolve_branch_o, 1'b0);
        check_bit("sfence_pending_o", sfence_pending_o, 1'b0);
        check_bit("flu_ready_o", flu_ready_o, 1'b1);
        check_addr("csr_addr_o", csr_addr_o, '0);
        check_target("sfence_vaddr_o", sfence_vaddr_o, '0);
        check_asid("sfence_asid_o", sfence_asid_o, '0);
        for (int i = 0; i < NUM_OPS; i++) begin
            run_op(i);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: verif/ex_stage_sva.sv
/*
 * Concurrent checks on the execute stage ports, bound into ex_stage
 */
`timescale 1ns/100ps

module ex_stage_sva (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_i,
    input logic alu_valid_i,
    input logic branch_valid_i,
    input logic csr_valid_i,
    input logic mult_valid_i,
    input logic csr_commit_i,
    input logic flu_valid_o,
    input logic flu_ready_o
);

    // Writeback port idle right after reset
    a_idle_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !flu_valid_o)
        else $error("flu_valid_o high in the first cycle after reset");

    // Unit strobes are one-hot or idle
    a_onehot_strobes: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i}))
        else $error("more than one unit strobe high");

    // Multiplier result one cycle after issue
    a_mult_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i && !flush_i |=> flu_valid_o)
        else $error("multiplier result missing after issue");

    // Held CSR keeps the issue port blocked
    a_csr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (csr_valid_i || !flu_ready_o) && !csr_commit_i && !flush_i |=> !flu_ready_o)
        else $error("flu_ready_o high while a CSR is held");

endmodule

bind ex_stage ex_stage_sva i_ex_stage_sva (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .alu_valid_i    (alu_valid_i),
    .branch_valid_i (branch_valid_i),
    .csr_valid_i    (csr_valid_i),
    .mult_valid_i   (mult_valid_i),
    .csr_commit_i   (csr_commit_i),
    .flu_valid_o    (flu_valid_o),
    .flu_ready_o    (flu_ready_o)
);

// File: src/ex_stage.sv
/*
 * Fixed-latency execute stage: issue gate, ALU, branch unit,
 * CSR buffer, multiplier and shared writeback port
 */
`timescale 1ns/100ps

module ex_stage import ex_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    // Operation record
    input  fu_op_t    operator_i,
    input  xlen_t     operand_a_i,
    input  xlen_t     operand_b_i,
    input  xlen_t     imm_i,
    input  trans_id_t trans_id_i,
    // Unit strobes, one-hot
    input  logic      alu_valid_i,
    input  logic      branch_valid_i,
    input  logic      csr_valid_i,
    input  logic      mult_valid_i,
    // Branch context
    input  vaddr_t    pc_i,
    input  logic      is_compressed_i,
    input  logic      predict_taken_i,
    input  vaddr_t    predict_target_i,
    // Forwarded sources for SFENCE.VMA
    input  vaddr_t    rs1_fwd_i,
    input  xlen_t     rs2_fwd_i,
    input  logic      csr_commit_i,
    // Writeback port
    output logic      flu_valid_o,
    output xlen_t     flu_result_o,
    output trans_id_t flu_trans_id_o,
    output logic      flu_ready_o,
    // Branch resolution
    output logic      resolve_branch_o,
    output vaddr_t    resolved_pc_o,
    output vaddr_t    resolved_target_o,
    output logic      resolved_taken_o,
    output logic      resolved_mispredict_o,
    // CSR and TLB flush side
    output csr_addr_t csr_addr_o,
    output logic      sfence_pending_o,
    output vaddr_t    sfence_vaddr_o,
    output asid_t     sfence_asid_o
);

    xlen_t     alu_a, alu_b, mult_a, mult_b;
    xlen_t     alu_result, csr_result, mult_result;
    vaddr_t    link_addr;
    logic      nonbranch_valid;
    logic      alu_cmp_res;
    logic      mult_valid;
    trans_id_t mult_trans_id;

    // ----------------------------------------
    // Input side
    // ----------------------------------------
    ex_issue_gate i_issue_gate (
        .clk_i, .rst_ni, .flush_i, .operator_i, .operand_a_i, .operand_b_i,
        .alu_valid_i, .branch_valid_i, .csr_valid_i, .mult_valid_i,
        .rs1_fwd_i, .rs2_fwd_i,
        .alu_a_o (alu_a), .alu_b_o (alu_b), .mult_a_o (mult_a), .mult_b_o (mult_b),
        .nonbranch_valid_o (nonbranch_valid),
        .sfence_pending_o, .sfence_vaddr_o, .sfence_asid_o
    );

    // ----------------------------------------
    // Units
    // ----------------------------------------
    alu i_alu (
        .operator_i, .operand_a_i (alu_a), .operand_b_i (alu_b),
        .result_o (alu_result), .cmp_res_o (alu_cmp_res)
    );

    // JALR base comes from the ALU copy
    branch_unit i_branch_unit (
        .operator_i, .imm_i, .operand_a_i (alu_a), .pc_i, .is_compressed_i,
        .branch_valid_i, .nonbranch_valid_i (nonbranch_valid), .cmp_res_i (alu_cmp_res),
        .predict_taken_i, .predict_target_i, .link_addr_o (link_addr),
        .resolve_branch_o, .resolved_pc_o, .resolved_target_o, .resolved_taken_o,
        .mispredict_o (resolved_mispredict_o)
    );

    // Sole source of the ready level
    csr_buffer i_csr_buffer (
        .clk_i, .rst_ni, .flush_i, .csr_valid_i, .csr_commit_i, .imm_i, .operand_a_i,
        .csr_ready_o (flu_ready_o), .csr_result_o (csr_result), .csr_addr_o
    );

    multiplier i_multiplier (
        .clk_i, .rst_ni, .flush_i, .mult_valid_i, .operator_i,
        .operand_a_i (mult_a), .operand_b_i (mult_b), .trans_id_i,
        .result_o (mult_result), .valid_o (mult_valid), .trans_id_o (mult_trans_id)
    );

    // ----------------------------------------
    // Output side
    // ----------------------------------------
    flu_writeback i_writeback (
        .alu_valid_i, .branch_valid_i, .csr_valid_i, .mult_valid_i (mult_valid),
        .alu_result_i (alu_result), .csr_result_i (csr_result), .mult_result_i (mult_result),
        .link_addr_i (link_addr), .trans_id_i, .mult_trans_id_i (mult_trans_id),
        .flu_valid_o, .flu_result_o, .flu_trans_id_o
    );

endmodule

// File: src/flu_writeback.sv
/*
 * Shared writeback port of the fixed-latency units:
 * result and tag select plus the combined valid
 */
`timescale 1ns/100ps

module flu_writeback import ex_pkg::*; (
    input  logic      alu_valid_i,
    input  logic      branch_valid_i,
    input  logic      csr_valid_i,
    input  logic      mult_valid_i,
    input  xlen_t     alu_result_i,
    input  xlen_t     csr_result_i,
    input  xlen_t     mult_result_i,
    input  vaddr_t    link_addr_i,
    input  trans_id_t trans_id_i,
    input  trans_id_t mult_trans_id_i,
    output logic      flu_valid_o,
    output xlen_t     flu_result_o,
    output trans_id_t flu_trans_id_o
);

    // Any unit writing back this cycle
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;

    always_comb begin
        // Link address when nothing else wins
        flu_result_o   = xlen_t'(link_addr_i);
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end else if (mult_valid_i) begin
            // Registered result carries its own tag
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

endmodule

// File: src/multiplier.sv
/*
 * Single-cycle unsigned 32x32 multiplier, low word for MUL and
 * high word for MULHU, with result, valid and tag registered
 */
`timescale 1ns/100ps

module multiplier import ex_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      mult_valid_i,
    input  fu_op_t    operator_i,
    input  xlen_t     operand_a_i,
    input  xlen_t     operand_b_i,
    input  trans_id_t trans_id_i,
    output xlen_t     result_o,
    output logic      valid_o,
    output trans_id_t trans_id_o
);

    logic [2*XLEN-1:0] product;
    xlen_t             result_sel;

    // Full-width product
    assign product    = {{XLEN{1'b0}}, operand_a_i} * {{XLEN{1'b0}}, operand_b_i};

    // Word select by operator
    assign result_sel = (operator_i == MULHU) ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

    // ----------------------------------------
    // Output stage
    // ----------------------------------------
    // Flush in the issue cycle drops the result
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= mult_valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_o   <= result_sel;
        // Tag as it was at issue
        trans_id_o <= trans_id_i;
    end

endmodule

// File: src/csr_buffer.sv
/*
 * One-entry CSR buffer: holds the CSR address until the
 * instruction commits and blocks further CSR issue meanwhile
 */
`timescale 1ns/100ps

module csr_buffer import ex_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      csr_valid_i,
    input  logic      csr_commit_i,
    input  xlen_t     imm_i,
    input  xlen_t     operand_a_i,
    output logic      csr_ready_o,
    output xlen_t     csr_result_o,
    output csr_addr_t csr_addr_o
);

    logic entry_valid_q;

    // Full entry blocks the issue port
    assign csr_ready_o  = !entry_valid_q;

    // Write data goes straight to commit
    assign csr_result_o = operand_a_i;

    // ----------------------------------------
    // Entry state
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            entry_valid_q <= 1'b0;
        end else if (flush_i) begin
            entry_valid_q <= 1'b0;
        end else if (csr_valid_i) begin
            entry_valid_q <= 1'b1;
        end else if (csr_commit_i) begin
            // Retired, slot free again
            entry_valid_q <= 1'b0;
        end
    end

    // Address from low bits of imm
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            csr_addr_o <= '0;
        end else if (csr_valid_i) begin
            csr_addr_o <= imm_i[CSR_ADDR_W-1:0];
        end
    end

endmodule

// File: src/branch_unit.sv
/*
 * Branch unit: target and link address, taken decision
 * and prediction check for branches and jumps
 */
`timescale 1ns/100ps

module branch_unit import ex_pkg::*; (
    input  fu_op_t operator_i,
    input  xlen_t  imm_i,
    input  xlen_t  operand_a_i,
    input  vaddr_t pc_i,
    input  logic   is_compressed_i,
    input  logic   branch_valid_i,
    input  logic   nonbranch_valid_i,
    input  logic   cmp_res_i,
    input  logic   predict_taken_i,
    input  vaddr_t predict_target_i,
    output vaddr_t link_addr_o,
    output logic   resolve_branch_o,
    output vaddr_t resolved_pc_o,
    output vaddr_t resolved_target_o,
    output logic   resolved_taken_o,
    output logic   mispredict_o
);

    vaddr_t incr;
    vaddr_t target_base;
    vaddr_t target_sum;
    vaddr_t target;
    logic   is_jump;
    logic   taken;
    logic   false_taken;

    // Next sequential pc, 2 for RVC
    assign incr        = is_compressed_i ? VLEN'(CINSTR_BYTES) : VLEN'(INSTR_BYTES);
    assign link_addr_o = pc_i + incr;

    // JALR is register relative, all others pc relative
    assign target_base = (operator_i == JALR) ? vaddr_t'(operand_a_i) : pc_i;
    assign target_sum  = target_base + vaddr_t'(imm_i);
    // JALR drops bit 0 of the sum
    assign target      = (operator_i == JALR) ? {target_sum[VLEN-1:1], 1'b0} : target_sum;

    assign is_jump = (operator_i == JAL) || (operator_i == JALR);
    assign taken   = (is_branch_op(operator_i) && cmp_res_i) || is_jump;

    // Predicted taken on something that is not a branch
    assign false_taken = nonbranch_valid_i && predict_taken_i;

    assign resolve_branch_o = branch_valid_i || false_taken;
    assign resolved_pc_o    = pc_i;

    // ----------------------------------------
    // Resolution
    // ----------------------------------------
    always_comb begin
        resolved_taken_o  = 1'b0;
        resolved_target_o = '0;
        mispredict_o      = 1'b0;
        if (branch_valid_i) begin
            resolved_taken_o  = taken;
            // Not taken resolves to fall-through
            resolved_target_o = taken ? target : link_addr_o;
            mispredict_o      = (predict_taken_i != taken) ||
                                (taken && (predict_target_i != target));
        end else if (false_taken) begin
            // Redirect back to the next instruction
            resolved_target_o = link_addr_o;
            mispredict_o      = 1'b1;
        end
    end

endmodule

// File: src/alu.sv
/*
 * Combinational ALU: add, subtract, logic, shifts,
 * set-less-than and the conditional branch compare
 */
`timescale 1ns/100ps

module alu import ex_pkg::*; (
    input  fu_op_t operator_i,
    input  xlen_t  operand_a_i,
    input  xlen_t  operand_b_i,
    output xlen_t  result_o,
    output logic   cmp_res_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    logic       equal;

    // Shift amount from low 5 bits only
    assign shamt = operand_b_i[4:0];

    // Shared comparators for SLT and branches
    assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
    assign lt_unsigned = operand_a_i < operand_b_i;
    assign equal       = operand_a_i == operand_b_i;

    // ----------------------------------------
    // Result mux
    // ----------------------------------------
    always_comb begin
        unique case (operator_i)
            SUB:     result_o = operand_a_i - operand_b_i;
            AND_OP:  result_o = operand_a_i & operand_b_i;
            OR_OP:   result_o = operand_a_i | operand_b_i;
            XOR_OP:  result_o = operand_a_i ^ operand_b_i;
            SLL:     result_o = operand_a_i << shamt;
            SRL:     result_o = operand_a_i >> shamt;
            SRA:     result_o = xlen_t'($signed(operand_a_i) >>> shamt);
            // Zero-extended compare flags
            SLT:     result_o = {{(XLEN-1){1'b0}}, lt_signed};
            SLTU:    result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            // Adder as default for ADD and the rest
            default: result_o = operand_a_i + operand_b_i;
        endcase
    end

    // ----------------------------------------
    // Branch compare
    // ----------------------------------------
    always_comb begin
        cmp_res_o = 1'b0;
        if (is_branch_op(operator_i)) begin
            unique case (operator_i)
                EQ:      cmp_res_o = equal;
                NE:      cmp_res_o = !equal;
                LTS:     cmp_res_o = lt_signed;
                GES:     cmp_res_o = !lt_signed;
                LTU:     cmp_res_o = lt_unsigned;
                default: cmp_res_o = !lt_unsigned;
            endcase
        end
    end

endmodule

// File: src/ex_issue_gate.sv
/*
 * Issue side of the execute stage: per-unit operand silencing,
 * the non-branch strobe for the branch unit and capture of the
 * SFENCE.VMA address and ASID for the TLB flush
 */
`timescale 1ns/100ps

module ex_issue_gate import ex_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    flush_i,
    input  fu_op_t  operator_i,
    input  xlen_t   operand_a_i,
    input  xlen_t   operand_b_i,
    input  logic    alu_valid_i,
    input  logic    branch_valid_i,
    input  logic    csr_valid_i,
    input  logic    mult_valid_i,
    input  vaddr_t  rs1_fwd_i,
    input  xlen_t   rs2_fwd_i,
    output xlen_t   alu_a_o,
    output xlen_t   alu_b_o,
    output xlen_t   mult_a_o,
    output xlen_t   mult_b_o,
    output logic    nonbranch_valid_o,
    output logic    sfence_pending_o,
    output vaddr_t  sfence_vaddr_o,
    output asid_t   sfence_asid_o
);

    logic alu_sel;
    logic sfence_issue;

    // ----------------------------------------
    // Operand silencing
    // ----------------------------------------
    // Branches borrow the ALU for the compare
    assign alu_sel  = alu_valid_i | branch_valid_i;
    assign alu_a_o  = alu_sel ? operand_a_i : '0;
    assign alu_b_o  = alu_sel ? operand_b_i : '0;
    assign mult_a_o = mult_valid_i ? operand_a_i : '0;
    assign mult_b_o = mult_valid_i ? operand_b_i : '0;

    // Any other unit busy, used to catch a false taken prediction
    assign nonbranch_valid_o = alu_valid_i | csr_valid_i | mult_valid_i;

    // ----------------------------------------
    // SFENCE.VMA capture
    // ----------------------------------------
    // SFENCE travels on the CSR strobe
    assign sfence_issue = csr_valid_i && (operator_i == SFENCE_VMA);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sfence_pending_o <= 1'b0;
        end else if (flush_i) begin
            sfence_pending_o <= 1'b0;
        end else if (sfence_issue) begin
            sfence_pending_o <= 1'b1;
        end
    end

    // Track forwarded rs1/rs2, frozen once an SFENCE shows up
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sfence_vaddr_o <= '0;
            sfence_asid_o  <= '0;
        end else if (!sfence_pending_o && !sfence_issue) begin
            sfence_vaddr_o <= rs1_fwd_i;
            sfence_asid_o  <= rs2_fwd_i[ASID_W-1:0];
        end
    end

endmodule

// File: src/ex_pkg.sv
/*
 * Shared definitions for the fixed-latency execute stage:
 * data, address, tag, ASID and CSR widths with their vector types,
 * the operator encoding and the branch operator helper
 */

package ex_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned VLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned ASID_W        = 9;
    localparam int unsigned CSR_ADDR_W    = 12;

    // Link address increments
    localparam int unsigned INSTR_BYTES   = 4;
    localparam int unsigned CINSTR_BYTES  = 2;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [VLEN-1:0]          vaddr_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [ASID_W-1:0]        asid_t;
    typedef logic [CSR_ADDR_W-1:0]    csr_addr_t;

    // ----------------------------------------
    // Operators
    // ----------------------------------------
    typedef enum logic [4:0] {
        ADD, SUB, AND_OP, OR_OP, XOR_OP,
        SLL, SRL, SRA, SLT, SLTU,
        // Conditional branches, kept contiguous
        EQ, NE, LTS, GES, LTU, GEU,
        JAL, JALR, CSR_RW, MUL, MULHU,
        SFENCE_VMA
    } fu_op_t;

    // True for the conditional branch compares
    function automatic logic is_branch_op(input fu_op_t op);
        return op inside {EQ, NE, LTS, GES, LTU, GEU};
    endfunction

endpackage
